// ==== src/mdu_pkg.sv ====
package mdu_pkg;

  // integer register width
  localparam int XLEN = 64;

  // funct3 of the M extension, OP and OP-32 major opcodes
  localparam logic [2:0] FUNCT3_MUL    = 3'd0;
  localparam logic [2:0] FUNCT3_MULH   = 3'd1;
  localparam logic [2:0] FUNCT3_MULHSU = 3'd2;
  localparam logic [2:0] FUNCT3_MULHU  = 3'd3;
  localparam logic [2:0] FUNCT3_DIV    = 3'd4;
  localparam logic [2:0] FUNCT3_DIVU   = 3'd5;
  localparam logic [2:0] FUNCT3_REM    = 3'd6;
  localparam logic [2:0] FUNCT3_REMU   = 3'd7;

endpackage

// ==== src/mdu_op_decode.sv ====
`timescale 1ns/10ps

module mdu_op_decode (
  input  logic [2:0]               funct3_i,
  input  logic                     word_i,
  input  logic [mdu_pkg::XLEN-1:0] rs1_i,
  input  logic [mdu_pkg::XLEN-1:0] rs2_i,
  output logic                     is_div_o,
  output logic                     a_signed_o,
  output logic                     b_signed_o,
  output logic                     mul_high_o,
  output logic                     rem_sel_o,
  output logic [mdu_pkg::XLEN-1:0] op_a_o,
  output logic [mdu_pkg::XLEN-1:0] op_b_o
);

  localparam int XL = mdu_pkg::XLEN;

  always_comb begin
    is_div_o   = funct3_i[2];
    a_signed_o = 1'b0;
    b_signed_o = 1'b0;
    mul_high_o = 1'b0;
    rem_sel_o  = 1'b0;
    case (funct3_i)
      mdu_pkg::FUNCT3_MUL: begin  // low half is the same either way
        a_signed_o = 1'b1;
        b_signed_o = 1'b1;
      end
      mdu_pkg::FUNCT3_MULH: begin
        a_signed_o = 1'b1;
        b_signed_o = 1'b1;
        mul_high_o = 1'b1;
      end
      mdu_pkg::FUNCT3_MULHSU: begin
        a_signed_o = 1'b1;
        mul_high_o = 1'b1;
      end
      mdu_pkg::FUNCT3_MULHU: mul_high_o = 1'b1;
      mdu_pkg::FUNCT3_DIV: begin
        a_signed_o = 1'b1;
        b_signed_o = 1'b1;
      end
      mdu_pkg::FUNCT3_REM: begin
        a_signed_o = 1'b1;
        b_signed_o = 1'b1;
        rem_sel_o  = 1'b1;
      end
      mdu_pkg::FUNCT3_REMU: rem_sel_o = 1'b1;
      default: ;  // DIVU, all unsigned
    endcase
  end

  // word ops run at full width on extended low words
  assign op_a_o = word_i ? {{(XL-32){a_signed_o & rs1_i[31]}}, rs1_i[31:0]} : rs1_i;
  assign op_b_o = word_i ? {{(XL-32){b_signed_o & rs2_i[31]}}, rs2_i[31:0]} : rs2_i;

endmodule

// ==== src/mdu_multiplier.sv ====
`timescale 1ns/10ps

module mdu_multiplier #(
  parameter int XLEN = 64
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            start_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,
  input  logic            a_signed_i,
  input  logic            b_signed_i,
  input  logic            mul_high_i,
  output logic [XLEN-1:0] result_o,
  output logic            done_o
);

  // operands carry one extra bit so one signed multiply covers all cases
  logic signed [XLEN:0]     a_q;
  logic signed [XLEN:0]     b_q;
  logic                     high_q;
  logic                     stage1_vld;
  logic signed [2*XLEN+1:0] product;

  // stage 1
  always_ff @(posedge clk) begin
    if (start_i) begin
      a_q    <= {a_signed_i & op_a_i[XLEN-1], op_a_i};
      b_q    <= {b_signed_i & op_b_i[XLEN-1], op_b_i};
      high_q <= mul_high_i;
    end
  end

  assign product = a_q * b_q;

  // stage 2
  always_ff @(posedge clk) begin
    if (stage1_vld) begin
      result_o <= high_q ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stage1_vld <= 1'b0;
      done_o     <= 1'b0;
    end else begin
      stage1_vld <= start_i;
      done_o     <= stage1_vld;  // two cycles after start
    end
  end

endmodule

// ==== src/mdu_divider.sv ====
`timescale 1ns/10ps

module mdu_divider #(
  parameter int XLEN = 64
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            start_i,
  input  logic [XLEN-1:0] dividend_i,
  input  logic [XLEN-1:0] divisor_i,
  input  logic            signed_i,
  output logic [XLEN-1:0] quotient_o,
  output logic [XLEN-1:0] remainder_o,
  output logic            ready_o
);

  localparam int CW = $clog2(XLEN);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_RUN  = 2'd1;
  localparam logic [1:0] S_FIX  = 2'd2;

  logic [1:0]      state;
  logic [CW-1:0]   step;
  logic [XLEN-1:0] quo_q;   // dividend shifts out, quotient bits shift in
  logic [XLEN-1:0] rem_q;
  logic [XLEN-1:0] dvsr_q;
  logic            neg_quo;
  logic            neg_rem;

  logic            a_neg;
  logic            b_neg;
  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;
  logic [XLEN:0]   shifted;
  logic [XLEN+1:0] trial;
  logic            fits;

  assign a_neg = signed_i & dividend_i[XLEN-1];
  assign b_neg = signed_i & divisor_i[XLEN-1];
  assign a_mag = a_neg ? -dividend_i : dividend_i;
  assign b_mag = b_neg ? -divisor_i : divisor_i;

  // one restoring step
  assign shifted = {rem_q, quo_q[XLEN-1]};
  assign trial   = {1'b0, shifted} - {2'b00, dvsr_q};
  assign fits    = ~trial[XLEN+1];

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= S_IDLE;
      step    <= '0;
      ready_o <= 1'b0;
    end else begin
      ready_o <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start_i) begin
            state <= S_RUN;
            step  <= '0;
          end
        end
        S_RUN: begin
          step <= step + 1'b1;
          if (step == CW'(XLEN-1)) begin
            state <= S_FIX;
          end
        end
        S_FIX: begin
          state   <= S_IDLE;
          ready_o <= 1'b1;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      S_IDLE: begin
        if (start_i) begin
          quo_q   <= a_mag;
          rem_q   <= '0;
          dvsr_q  <= b_mag;
          // zero divisor keeps an all-ones quotient
          neg_quo <= (a_neg ^ b_neg) & (|divisor_i);
          neg_rem <= a_neg;
        end
      end
      S_RUN: begin
        quo_q <= {quo_q[XLEN-2:0], fits};
        rem_q <= fits ? trial[XLEN-1:0] : shifted[XLEN-1:0];
      end
      S_FIX: begin
        if (neg_quo) begin
          quo_q <= -quo_q;
        end
        if (neg_rem) begin
          rem_q <= -rem_q;  // remainder takes the dividend sign
        end
      end
      default: ;
    endcase
  end

  // min / -1 gives magnitude 2^(XLEN-1), negation wraps back to min
  assign quotient_o  = quo_q;
  assign remainder_o = rem_q;

endmodule

// ==== src/mdu_result_stage.sv ====
`timescale 1ns/10ps

module mdu_result_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start_i,
  input  logic                     rem_sel_i,
  input  logic                     word_i,
  input  logic [mdu_pkg::XLEN-1:0] mul_result_i,
  input  logic                     mul_done_i,
  input  logic [mdu_pkg::XLEN-1:0] quotient_i,
  input  logic [mdu_pkg::XLEN-1:0] remainder_i,
  input  logic                     div_ready_i,
  output logic                     busy_o,
  output logic [mdu_pkg::XLEN-1:0] result_o,
  output logic                     result_valid_o
);

  localparam int XL = mdu_pkg::XLEN;

  logic          rem_sel_q;
  logic          word_q;
  logic          done;
  logic [XL-1:0] pick;

  assign done = mul_done_i | div_ready_i;
  assign pick = div_ready_i ? (rem_sel_q ? remainder_i : quotient_i) : mul_result_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_o         <= 1'b0;
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= done;
      if (done) begin
        busy_o <= 1'b0;  // drops with the valid pulse
      end else if (start_i) begin
        busy_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      rem_sel_q <= rem_sel_i;
      word_q    <= word_i;
    end
    if (done) begin
      result_o <= word_q ? {{(XL-32){pick[31]}}, pick[31:0]} : pick;
    end
  end

endmodule

// ==== src/mdu_top.sv ====
`timescale 1ns/10ps

module mdu_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     op_valid_i,
  input  logic [2:0]               funct3_i,
  input  logic                     word_i,
  input  logic [mdu_pkg::XLEN-1:0] rs1_i,
  input  logic [mdu_pkg::XLEN-1:0] rs2_i,
  output logic [mdu_pkg::XLEN-1:0] result_o,
  output logic                     result_valid_o,
  output logic                     busy_o
);

  logic                     is_div;
  logic                     a_signed;
  logic                     b_signed;
  logic                     mul_high;
  logic                     rem_sel;
  logic [mdu_pkg::XLEN-1:0] op_a;
  logic [mdu_pkg::XLEN-1:0] op_b;
  logic [mdu_pkg::XLEN-1:0] mul_result;
  logic [mdu_pkg::XLEN-1:0] quotient;
  logic [mdu_pkg::XLEN-1:0] remainder;
  logic                     mul_done;
  logic                     div_ready;
  logic                     accept;
  logic                     mul_start;
  logic                     div_start;

  assign accept    = op_valid_i & ~busy_o;  // strobes while busy are dropped
  assign mul_start = accept & ~is_div;
  assign div_start = accept & is_div;

  mdu_op_decode u_decode (
    .funct3_i   (funct3_i),
    .word_i     (word_i),
    .rs1_i      (rs1_i),
    .rs2_i      (rs2_i),
    .is_div_o   (is_div),
    .a_signed_o (a_signed),
    .b_signed_o (b_signed),
    .mul_high_o (mul_high),
    .rem_sel_o  (rem_sel),
    .op_a_o     (op_a),
    .op_b_o     (op_b)
  );

  mdu_multiplier #(
    .XLEN (mdu_pkg::XLEN)
  ) u_mul (
    .clk        (clk),
    .rst        (rst),
    .start_i    (mul_start),
    .op_a_i     (op_a),
    .op_b_i     (op_b),
    .a_signed_i (a_signed),
    .b_signed_i (b_signed),
    .mul_high_i (mul_high),
    .result_o   (mul_result),
    .done_o     (mul_done)
  );

  mdu_divider #(
    .XLEN (mdu_pkg::XLEN)
  ) u_div (
    .clk         (clk),
    .rst         (rst),
    .start_i     (div_start),
    .dividend_i  (op_a),
    .divisor_i   (op_b),
    .signed_i    (a_signed),
    .quotient_o  (quotient),
    .remainder_o (remainder),
    .ready_o     (div_ready)
  );

  mdu_result_stage u_result (
    .clk            (clk),
    .rst            (rst),
    .start_i        (accept),
    .rem_sel_i      (rem_sel),
    .word_i         (word_i),
    .mul_result_i   (mul_result),
    .mul_done_i     (mul_done),
    .quotient_i     (quotient),
    .remainder_i    (remainder),
    .div_ready_i    (div_ready),
    .busy_o         (busy_o),
    .result_o       (result_o),
    .result_valid_o (result_valid_o)
  );

endmodule

// ==== testbench/tb_mdu_ref.svh ====
`ifndef TB_MDU_REF_SVH
`define TB_MDU_REF_SVH

// expected value of one op, straight from the RISC-V M definitions
function automatic logic [63:0] expected_result(input logic [2:0] f3, input logic w,
                                                input logic [63:0] a, input logic [63:0] b);
  logic signed [63:0]  sa;
  logic signed [63:0]  sb;
  logic signed [31:0]  wa;
  logic signed [31:0]  wb;
  logic signed [127:0] big_a;
  logic signed [127:0] big_b;
  logic [127:0]        prod;
  logic [63:0]         res;
  logic [31:0]         wres;
  sa    = a;
  sb    = b;
  wa    = a[31:0];
  wb    = b[31:0];
  big_a = sa;  // sign-extends
  big_b = sb;
  res   = '0;
  wres  = '0;
  case (f3)
    mdu_pkg::FUNCT3_MUL: begin
      res  = a * b;
      wres = a[31:0] * b[31:0];
    end
    mdu_pkg::FUNCT3_MULH: begin
      prod = big_a * big_b;
      res  = prod[127:64];
    end
    mdu_pkg::FUNCT3_MULHSU: begin
      prod = big_a * $signed({64'd0, b});
      res  = prod[127:64];
    end
    mdu_pkg::FUNCT3_MULHU: begin
      prod = {64'd0, a} * {64'd0, b};
      res  = prod[127:64];
    end
    mdu_pkg::FUNCT3_DIV, mdu_pkg::FUNCT3_REM: begin
      if (b == 64'd0) begin
        res = (f3 == mdu_pkg::FUNCT3_DIV) ? '1 : a;
      end else if (a == {1'b1, 63'd0} && b == '1) begin  // overflow
        res = (f3 == mdu_pkg::FUNCT3_DIV) ? a : '0;
      end else if (f3 == mdu_pkg::FUNCT3_DIV) begin
        res = sa / sb;
      end else begin
        res = sa % sb;  // sign follows the dividend
      end
      if (b[31:0] == 32'd0) begin
        wres = (f3 == mdu_pkg::FUNCT3_DIV) ? '1 : a[31:0];
      end else if (a[31:0] == {1'b1, 31'd0} && b[31:0] == '1) begin
        wres = (f3 == mdu_pkg::FUNCT3_DIV) ? a[31:0] : '0;
      end else if (f3 == mdu_pkg::FUNCT3_DIV) begin
        wres = wa / wb;
      end else begin
        wres = wa % wb;
      end
    end
    default: begin  // DIVU and REMU
      if (b == 64'd0) begin
        res = (f3 == mdu_pkg::FUNCT3_DIVU) ? '1 : a;
      end else begin
        res = (f3 == mdu_pkg::FUNCT3_DIVU) ? a / b : a % b;
      end
      if (b[31:0] == 32'd0) begin
        wres = (f3 == mdu_pkg::FUNCT3_DIVU) ? '1 : a[31:0];
      end else begin
        wres = (f3 == mdu_pkg::FUNCT3_DIVU) ? a[31:0] / b[31:0] : a[31:0] % b[31:0];
      end
    end
  endcase
  return w ? {{32{wres[31]}}, wres} : res;
endfunction

`endif

// ==== testbench/tb_mdu.sv ====
`timescale 1ns/10ps

module tb_mdu;

  localparam int XL              = mdu_pkg::XLEN;
  localparam int CLK_PERIOD      = 4;
  localparam int WATCHDOG_CYCLES = 300 * (XL + 10);

  logic          clk;
  logic          rst;
  logic          op_valid;
  logic [2:0]    funct3;
  logic          word;
  logic [XL-1:0] rs1;
  logic [XL-1:0] rs2;
  logic [XL-1:0] result;
  logic          result_valid;
  logic          busy;

  int            seed          = 7;
  int            mismatches    = 0;
  int            protocol_errs = 0;
  logic [XL-1:0] exp_q[$];
  string         name_q[$];
  string         mnem[8] = '{"MUL", "MULH", "MULHSU", "MULHU", "DIV", "DIVU", "REM", "REMU"};
  logic [XL-1:0] corners[4] = '{64'd0, 64'd1, {XL{1'b1}}, {1'b1, 63'd0}};
  logic [2:0]    word_f3[5] = '{mdu_pkg::FUNCT3_MUL, mdu_pkg::FUNCT3_DIV, mdu_pkg::FUNCT3_DIVU,
                                mdu_pkg::FUNCT3_REM, mdu_pkg::FUNCT3_REMU};

  `include "tb_mdu_ref.svh"

  mdu_top u_mdu_top (
    .clk            (clk),
    .rst            (rst),
    .op_valid_i     (op_valid),
    .funct3_i       (funct3),
    .word_i         (word),
    .rs1_i          (rs1),
    .rs2_i          (rs2),
    .result_o       (result),
    .result_valid_o (result_valid),
    .busy_o         (busy)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [XL-1:0] random_word();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic compare_values(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      mismatches++;
    end
  endtask

  task automatic drive_op(input logic [2:0] f3, input logic w, input logic [XL-1:0] a,
                          input logic [XL-1:0] b);
    op_valid <= 1'b1;
    funct3   <= f3;
    word     <= w;
    rs1      <= a;
    rs2      <= b;
  endtask

  // counts edges from the accept edge until result_valid_o is seen
  task automatic wait_result(input string name, input int lat_exp, input int elapsed);
    int lat;
    lat = elapsed;
    do begin
      @(posedge clk);
      lat++;
    end while (!result_valid && lat < lat_exp + 10);
    if (result_valid) begin
      compare_values({name, " latency"}, 64'(lat_exp), 64'(lat));
    end else begin
      $display("%s: result_valid_o never rose within %0d cycles of the accept edge", name, lat);
      protocol_errs++;
      void'(exp_q.pop_front());
      void'(name_q.pop_front());
    end
  endtask

  task automatic issue_op(input string tag, input logic [2:0] f3, input logic w,
                          input logic [XL-1:0] a, input logic [XL-1:0] b);
    string name;
    name = $sformatf("%s %s%s", tag, mnem[f3], w ? "W" : "");
    exp_q.push_back(expected_result(f3, w, a, b));
    name_q.push_back(name);
    @(posedge clk);
    drive_op(f3, w, a, b);
    @(posedge clk);  // accept edge
    op_valid <= 1'b0;
    wait_result(name, f3[2] ? XL + 3 : 3, 0);
  endtask

  // every result pulse is matched against the oldest outstanding op
  always @(posedge clk) begin : compare_results
    string name;
    if (result_valid) begin
      if (name_q.size() == 0) begin
        $display("result_valid_o pulsed with no operation outstanding at %0t", $time);
        protocol_errs++;
      end else begin
        name = name_q.pop_front();
        compare_values(name, exp_q.pop_front(), result);
        compare_values({name, " busy_o at result"}, 64'd0, 64'(busy));
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    logic [XL-1:0] a;
    logic [XL-1:0] b;
    rst      = 1'b1;
    op_valid = 1'b0;
    funct3   = '0;
    word     = 1'b0;
    rs1      = '0;
    rs2      = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    repeat (6) begin  // idle, no strobe yet
      @(posedge clk);
      compare_values("reset busy_o", 64'd0, 64'(busy));
      compare_values("reset result_valid_o", 64'd0, 64'(result_valid));
    end

    for (int f = 0; f < 4; f++) begin
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
          issue_op("corner", 3'(f), 1'b0, corners[i], corners[j]);
        end
      end
    end
    for (int i = 0; i < 60; i++) begin
      issue_op("random", 3'(i % 4), 1'b0, random_word(), random_word());
    end
    for (int i = 0; i < 60; i++) begin
      a = random_word();
      b = $signed(random_word()) >>> (i % 64);  // spread of quotient sizes
      issue_op("random", 3'(4 + i % 4), 1'b0, a, b);
    end

    for (int f = 4; f < 8; f++) begin
      issue_op("div by zero", 3'(f), 1'b0, random_word(), 64'd0);
      b = random_word();
      b[31:0] = '0;  // upper half garbage
      issue_op("div by zero", 3'(f), 1'b1, random_word(), b);
    end
    issue_op("overflow", mdu_pkg::FUNCT3_DIV, 1'b0, {1'b1, 63'd0}, '1);
    issue_op("overflow", mdu_pkg::FUNCT3_REM, 1'b0, {1'b1, 63'd0}, '1);
    a = random_word();
    b = random_word();
    a[31:0] = 32'h8000_0000;
    b[31:0] = '1;
    issue_op("overflow", mdu_pkg::FUNCT3_DIV, 1'b1, a, b);
    issue_op("overflow", mdu_pkg::FUNCT3_REM, 1'b1, a, b);

    for (int i = 0; i < 20; i++) begin
      issue_op("word", word_f3[i % 5], 1'b1, random_word(), random_word());
    end

    // second strobe arrives mid-divide and must be dropped
    a = random_word();
    b = random_word() >> 20;
    exp_q.push_back(expected_result(mdu_pkg::FUNCT3_DIV, 1'b0, a, b));
    name_q.push_back("busy DIV");
    @(posedge clk);
    drive_op(mdu_pkg::FUNCT3_DIV, 1'b0, a, b);
    @(posedge clk);
    op_valid <= 1'b0;
    @(posedge clk);
    drive_op(mdu_pkg::FUNCT3_MUL, 1'b0, b, a);
    @(posedge clk);
    compare_values("busy_o during second strobe", 64'd1, 64'(busy));
    op_valid <= 1'b0;
    wait_result("busy DIV", XL + 3, 2);
    repeat (XL + 10) @(posedge clk);  // room for a stray second pulse

    $display("summary: %0d value mismatches, %0d protocol errors", mismatches, protocol_errs);
    if (mismatches == 0 && protocol_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+testbench
src/mdu_pkg.sv
src/mdu_op_decode.sv
src/mdu_multiplier.sv
src/mdu_divider.sv
src/mdu_result_stage.sv
src/mdu_top.sv
testbench/tb_mdu.sv

// ==== Makefile ====
TOP = tb_mdu

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
